// File: rtl/ternary_matmul_pkg.sv
// ternary matmul shared constants for byte widths, base-3 weight packing and result scaling
`default_nettype none

package ternary_matmul_pkg;

    // weight and activation bytes
    localparam int BYTE_W = 8;

    // five base-3 digits fit in one byte since 3^5 = 243
    localparam int TRITS_PER_BYTE = 5;

    // largest byte that still holds five valid trits
    // bytes above this decode as all-zero weights
    localparam int MAX_PACKED = 242;

    // signed accumulator width, sums wrap at this size
    localparam int ACC_W = 17;

    // result byte is taken from bits 15..8 of an accumulator
    localparam int OUT_SHIFT = 8;

    // window length used when the top level is not overridden
    localparam int DEFAULT_SLICES = 2;

endpackage

`default_nettype wire

// File: rtl/trit_unpacker.sv
// trit unpacker, splits a packed weight byte into five ternary zero/sign flags
`default_nettype none

module trit_unpacker (
    input  logic [ternary_matmul_pkg::BYTE_W-1:0]         packed_byte,
    output logic [ternary_matmul_pkg::TRITS_PER_BYTE-1:0] weight_zero,
    output logic [ternary_matmul_pkg::TRITS_PER_BYTE-1:0] weight_sign
);
    import ternary_matmul_pkg::*;

    // base-3 decode by repeated division, constant divisor keeps it small
    // digit 0 -> weight 0, digit 1 -> +1, digit 2 -> -1
    always_comb begin
        logic [BYTE_W-1:0] rest;
        logic [1:0]        digit;

        rest        = packed_byte;
        digit       = '0;
        weight_zero = '0;
        weight_sign = '0;

        if (packed_byte > BYTE_W'(MAX_PACKED)) begin
            // out of range bytes act as five zero weights
            weight_zero = '1;
        end else begin
            // least significant digit lands on the highest weight index
            for (int i = 0; i < TRITS_PER_BYTE; i++) begin
                digit = 2'(rest % 3);
                rest  = rest / 3;
                weight_zero[TRITS_PER_BYTE-1-i] = (digit == 2'd0);
                weight_sign[TRITS_PER_BYTE-1-i] = (digit == 2'd2);
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/window_loader.sv
// window loader, gathers a window of weight flags and activations and replays it by column
`default_nettype none

module window_loader #(
    parameter int SLICES = ternary_matmul_pkg::DEFAULT_SLICES
) (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic                                                 read_out,
    input  logic        [ternary_matmul_pkg::TRITS_PER_BYTE-1:0] weight_zero,
    input  logic        [ternary_matmul_pkg::TRITS_PER_BYTE-1:0] weight_sign,
    input  logic signed [ternary_matmul_pkg::BYTE_W-1:0]         activation,
    output logic [ternary_matmul_pkg::TRITS_PER_BYTE*SLICES-1:0] win_zero,
    output logic [ternary_matmul_pkg::TRITS_PER_BYTE*SLICES-1:0] win_sign,
    output logic signed [ternary_matmul_pkg::BYTE_W-1:0]         col_act,
    output logic [((SLICES > 1) ? $clog2(SLICES) : 1)-1:0]       col_index
);
    import ternary_matmul_pkg::*;

    localparam int ROWS  = TRITS_PER_BYTE * SLICES;
    localparam int COLS  = SLICES;
    localparam int IDX_W = (SLICES > 1) ? $clog2(SLICES) : 1;

    // position of the incoming byte pair inside the window
    logic [IDX_W-1:0] slice_count;
    logic             window_done;

    // collectors, filled one slot per cycle
    logic [ROWS-1:0]        zero_col;
    logic [ROWS-1:0]        sign_col;
    logic [COLS*BYTE_W-1:0] act_col;

    // collectors with the last slot taken straight from the inputs
    logic [ROWS-1:0]        zero_full;
    logic [ROWS-1:0]        sign_full;
    logic [COLS*BYTE_W-1:0] act_full;

    // activations of the window under compute
    logic [COLS*BYTE_W-1:0] act_win;

    assign window_done = (slice_count == IDX_W'(SLICES - 1));

    // the final byte of a window is still on the inputs when the window completes
    always_comb begin
        zero_full = zero_col;
        sign_full = sign_col;
        act_full  = act_col;
        zero_full[ROWS-TRITS_PER_BYTE +: TRITS_PER_BYTE] = weight_zero;
        sign_full[ROWS-TRITS_PER_BYTE +: TRITS_PER_BYTE] = weight_sign;
        act_full[(COLS-1)*BYTE_W +: BYTE_W]              = activation;
    end

    always_ff @(posedge clk) begin
        if (reset || read_out) begin
            // cleared window has zero activations, so it adds nothing
            slice_count <= '0;
            zero_col    <= '0;
            sign_col    <= '0;
            act_col     <= '0;
            win_zero    <= '0;
            win_sign    <= '0;
            act_win     <= '0;
        end else begin
            // byte k covers rows 5k..5k+4 and column k
            zero_col[slice_count*TRITS_PER_BYTE +: TRITS_PER_BYTE] <= weight_zero;
            sign_col[slice_count*TRITS_PER_BYTE +: TRITS_PER_BYTE] <= weight_sign;
            act_col[slice_count*BYTE_W +: BYTE_W]                  <= activation;

            if (window_done) begin
                slice_count <= '0;
                // hand the full window over to compute
                win_zero <= zero_full;
                win_sign <= sign_full;
                act_win  <= act_full;
            end else begin
                slice_count <= slice_count + 1'b1;
            end
        end
    end

    // compute runs one column per cycle in step with the collection counter,
    // so column 0 follows the handover edge directly
    assign col_index = slice_count;
    assign col_act   = act_win[slice_count*BYTE_W +: BYTE_W];

endmodule

`default_nettype wire

// File: rtl/mac_array.sv
// mac array, ternary accumulate of one activation column into every row per cycle
`default_nettype none

module mac_array #(
    parameter int SLICES = ternary_matmul_pkg::DEFAULT_SLICES
) (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic                                                 read_out,
    input  logic [ternary_matmul_pkg::TRITS_PER_BYTE*SLICES-1:0] win_zero,
    input  logic [ternary_matmul_pkg::TRITS_PER_BYTE*SLICES-1:0] win_sign,
    input  logic signed [ternary_matmul_pkg::BYTE_W-1:0]         col_act,
    input  logic [((SLICES > 1) ? $clog2(SLICES) : 1)-1:0]       col_index,
    output logic [ternary_matmul_pkg::TRITS_PER_BYTE*SLICES*SLICES
                  *ternary_matmul_pkg::ACC_W-1:0]                acc_flat
);
    import ternary_matmul_pkg::*;

    localparam int ROWS  = TRITS_PER_BYTE * SLICES;
    localparam int COLS  = SLICES;
    localparam int IDX_W = (SLICES > 1) ? $clog2(SLICES) : 1;

    // activation sign extended once, shared by every row
    logic signed [ACC_W-1:0] addend;

    assign addend = {{(ACC_W - BYTE_W){col_act[BYTE_W-1]}}, col_act};

    for (genvar r = 0; r < ROWS; r++) begin : g_row
        for (genvar c = 0; c < COLS; c++) begin : g_col
            logic signed [ACC_W-1:0] acc;
            logic                    hit;

            // only the addressed column moves, zero weights hold
            assign hit = (col_index == IDX_W'(c)) && !win_zero[r];

            always_ff @(posedge clk) begin
                if (reset || read_out) begin
                    acc <= '0;
                end else if (hit) begin
                    // -1 weight subtracts, +1 adds; wraps at ACC_W bits
                    if (win_sign[r]) begin
                        acc <= acc - addend;
                    end else begin
                        acc <= acc + addend;
                    end
                end
            end

            // row-major, element 0 in the low bits
            assign acc_flat[(r*COLS + c)*ACC_W +: ACC_W] = acc;
        end
    end

endmodule

`default_nettype wire

// File: rtl/result_queue.sv
// result queue, snapshots the accumulators and shifts them out as scaled bytes
`default_nettype none

module result_queue #(
    parameter int SLICES = ternary_matmul_pkg::DEFAULT_SLICES
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         read_out,
    input  logic [ternary_matmul_pkg::TRITS_PER_BYTE*SLICES*SLICES
                  *ternary_matmul_pkg::ACC_W-1:0]        acc_flat,
    output logic [ternary_matmul_pkg::BYTE_W-1:0]        result
);
    import ternary_matmul_pkg::*;

    localparam int ROWS  = TRITS_PER_BYTE * SLICES;
    localparam int COLS  = SLICES;
    localparam int ELEMS = ROWS * COLS;

    // element 0 sits in the low ACC_W bits
    logic [ELEMS*ACC_W-1:0] queue;

    always_ff @(posedge clk) begin
        if (reset) begin
            queue <= '0;
        end else if (read_out) begin
            // snapshot of the accumulators as they are before clearing
            queue <= acc_flat;
        end else begin
            // next element moves to the front, zeros come in from the top
            queue <= queue >> ACC_W;
        end
    end

    // arithmetic shift by OUT_SHIFT keeping the low byte, i.e. bits 15..8
    assign result = queue[OUT_SHIFT +: BYTE_W];

endmodule

`default_nettype wire

// File: rtl/ternary_matmul.sv
// ternary matmul top, unpacks weights, builds windows, accumulates and queues results
`default_nettype none

module ternary_matmul #(
    parameter int SLICES = ternary_matmul_pkg::DEFAULT_SLICES
) (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic [ternary_matmul_pkg::BYTE_W-1:0]       weights,
    input  logic signed [ternary_matmul_pkg::BYTE_W-1:0] activations,
    input  logic                                        read_out,
    output logic [ternary_matmul_pkg::BYTE_W-1:0]       result
);
    import ternary_matmul_pkg::*;

    localparam int ROWS  = TRITS_PER_BYTE * SLICES;
    localparam int COLS  = SLICES;
    localparam int IDX_W = (SLICES > 1) ? $clog2(SLICES) : 1;

    // decoded flags of the current weight byte
    logic [TRITS_PER_BYTE-1:0] weight_zero;
    logic [TRITS_PER_BYTE-1:0] weight_sign;

    // window under compute
    logic [ROWS-1:0]          win_zero;
    logic [ROWS-1:0]          win_sign;
    logic signed [BYTE_W-1:0] col_act;
    logic [IDX_W-1:0]         col_index;

    // all accumulators, row-major
    logic [ROWS*COLS*ACC_W-1:0] acc_flat;

    trit_unpacker trit_unpacker_inst (
        .packed_byte (weights),
        .weight_zero (weight_zero),
        .weight_sign (weight_sign)
    );

    window_loader #(
        .SLICES (SLICES)
    ) window_loader_inst (
        .clk         (clk),
        .reset       (reset),
        .read_out    (read_out),
        .weight_zero (weight_zero),
        .weight_sign (weight_sign),
        .activation  (activations),
        .win_zero    (win_zero),
        .win_sign    (win_sign),
        .col_act     (col_act),
        .col_index   (col_index)
    );

    mac_array #(
        .SLICES (SLICES)
    ) mac_array_inst (
        .clk       (clk),
        .reset     (reset),
        .read_out  (read_out),
        .win_zero  (win_zero),
        .win_sign  (win_sign),
        .col_act   (col_act),
        .col_index (col_index),
        .acc_flat  (acc_flat)
    );

    // read_out loads the queue on the same edge the accumulators clear
    result_queue #(
        .SLICES (SLICES)
    ) result_queue_inst (
        .clk      (clk),
        .reset    (reset),
        .read_out (read_out),
        .acc_flat (acc_flat),
        .result   (result)
    );

endmodule

`default_nettype wire

// File: sim/tb_ternary_matmul.sv
// ternary matmul testbench, table-driven windows checked against a base-3 reference model
`default_nettype none

module tb_ternary_matmul;
    import ternary_matmul_pkg::*;

    localparam int SLICES = DEFAULT_SLICES;
    localparam int ROWS   = TRITS_PER_BYTE * SLICES;
    localparam int COLS   = SLICES;
    localparam int ELEMS  = ROWS * COLS;

    localparam int          NUM_TESTS      = 12;
    localparam int          TIMEOUT_CYCLES = 100;
    localparam logic [31:0] LFSR_SEED      = 32'h363b_c822;
    // x^32 + x^22 + x^2 + x + 1, right-shifting form
    localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

    // weight modes of a table entry
    localparam int MODE_FIXED  = 0;
    localparam int MODE_RANDOM = 1;
    localparam int MODE_HIGH   = 2;

    logic                     clk;
    logic                     reset;
    logic [BYTE_W-1:0]        weights;
    logic signed [BYTE_W-1:0] activations;
    logic                     read_out;
    logic [BYTE_W-1:0]        result;

    // stimulus table, one column per field
    string test_name    [NUM_TESTS];
    int    test_windows [NUM_TESTS];
    int    weight_mode  [NUM_TESTS];
    int    weight_value [NUM_TESTS];
    logic  act_random   [NUM_TESTS];
    int    act_value    [NUM_TESTS];

    // reference accumulators, full precision
    int model_acc [ROWS][COLS];

    logic [31:0] lfsr_state;

    // where the DUT slice counter should be for the next sampled pair
    int phase;

    ternary_matmul ternary_matmul_inst (
        .clk         (clk),
        .reset       (reset),
        .weights     (weights),
        .activations (activations),
        .read_out    (read_out),
        .result      (result)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ LFSR_TAPS;
        end
        return next;
    endfunction

    // one lfsr step per bit, lsb is the bit taken
    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // weight of trit index 0..4, index 4 is the least significant base-3 digit
    function automatic int trit_weight(input int packed_value, input int index);
        int divisor;
        int digit;
        int weight;
        divisor = 1;
        weight  = 0;
        for (int k = index; k < TRITS_PER_BYTE - 1; k++) begin
            divisor = divisor * 3;
        end
        digit = (packed_value / divisor) % 3;
        if (packed_value > MAX_PACKED) begin
            weight = 0;
        end else if (digit == 1) begin
            weight = 1;
        end else if (digit == 2) begin
            weight = -1;
        end
        return weight;
    endfunction

    // element index is row-major, wrap to accumulator width then scale
    function automatic logic [BYTE_W-1:0] expected_byte(input int element);
        logic [31:0]      full;
        logic [ACC_W-1:0] wrapped;
        full    = model_acc[element / COLS][element % COLS];
        wrapped = full[ACC_W-1:0];
        return BYTE_W'(wrapped >> OUT_SHIFT);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch test=%s expected=%0h actual=%0h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    // inputs change 1 unit after an edge and are sampled at the next one
    task automatic drive_cycle(input logic [BYTE_W-1:0] w, input logic [BYTE_W-1:0] a,
                               input logic ro);
        weights     = w;
        activations = a;
        read_out    = ro;
        @(posedge clk);
        #1;
        if (ro) begin
            phase = 0;
        end else begin
            phase = (phase + 1) % SLICES;
        end
    endtask

    // idle zero cycles until the next pair lands in slot 0 of a window
    task automatic align_window();
        int cycles;
        cycles = 0;
        while (phase != 0) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("timeout while aligning the stimulus to a window start");
                $display("Test FAILED");
                $fatal(1, "align timeout");
            end else begin
                drive_cycle('0, '0, 1'b0);
                cycles++;
            end
        end
    endtask

    task automatic set_entry(input int idx, input string name, input int windows,
                             input int mode, input int wval, input logic arand,
                             input int aval);
        test_name[idx]    = name;
        test_windows[idx] = windows;
        weight_mode[idx]  = mode;
        weight_value[idx] = wval;
        act_random[idx]   = arand;
        act_value[idx]    = aval;
    endtask

    task automatic load_table();
        // readout with nothing accumulated
        set_entry(0, "empty", 0, MODE_FIXED, 0, 1'b0, 0);
        // 121 is digits 11111, all +1; 242 is 22222, all -1
        set_entry(1, "all_plus", 8, MODE_FIXED, 121, 1'b0, 120);
        set_entry(2, "all_minus", 8, MODE_FIXED, 242, 1'b0, 120);
        set_entry(3, "minus_neg_act", 8, MODE_FIXED, 242, 1'b0, -128);
        set_entry(4, "plus_random_act", 6, MODE_FIXED, 121, 1'b1, 0);
        // out of range and zero bytes add nothing
        // 244 has a nonzero low digit, so only the range limit keeps it silent
        set_entry(5, "byte_244", 12, MODE_FIXED, 244, 1'b1, 0);
        set_entry(6, "byte_255", 12, MODE_FIXED, 255, 1'b1, 0);
        set_entry(7, "high_bytes", 12, MODE_HIGH, 0, 1'b1, 0);
        set_entry(8, "byte_zero", 12, MODE_FIXED, 0, 1'b1, 0);
        // back to back random runs, second one must not see the first
        set_entry(9, "random_a", 40, MODE_RANDOM, 0, 1'b1, 0);
        set_entry(10, "random_b", 40, MODE_RANDOM, 0, 1'b1, 0);
        // 600 * 127 per element goes past the signed 17 bit range
        set_entry(11, "wrap", 600, MODE_FIXED, 121, 1'b0, 127);
    endtask

    task automatic run_test(input int idx);
        logic [BYTE_W-1:0]        win_weight [SLICES];
        logic signed [BYTE_W-1:0] win_act    [SLICES];
        logic [31:0]              bits;
        int                       act_int;
        string                    label;

        foreach (model_acc[r, c]) begin
            model_acc[r][c] = 0;
        end
        align_window();

        for (int n = 0; n < test_windows[idx]; n++) begin
            // build one window of byte pairs
            for (int k = 0; k < SLICES; k++) begin
                case (weight_mode[idx])
                    MODE_RANDOM: begin
                        draw_bits(8, bits);
                        win_weight[k] = BYTE_W'(bits % 243);
                    end
                    MODE_HIGH: begin
                        draw_bits(4, bits);
                        win_weight[k] = BYTE_W'(243 + bits % 13);
                    end
                    default: begin
                        win_weight[k] = BYTE_W'(weight_value[idx]);
                    end
                endcase
                if (act_random[idx]) begin
                    draw_bits(8, bits);
                    win_act[k] = bits[BYTE_W-1:0];
                end else begin
                    win_act[k] = BYTE_W'(act_value[idx]);
                end
            end

            // outer product, byte k owns rows 5k..5k+4
            for (int k = 0; k < SLICES; k++) begin
                for (int t = 0; t < TRITS_PER_BYTE; t++) begin
                    for (int c = 0; c < COLS; c++) begin
                        act_int = win_act[c];
                        model_acc[k*TRITS_PER_BYTE + t][c] += trit_weight(win_weight[k], t)
                                                              * act_int;
                    end
                end
            end

            for (int k = 0; k < SLICES; k++) begin
                drive_cycle(win_weight[k], win_act[k], 1'b0);
            end
        end

        // let the last window finish compute before the readout
        for (int f = 0; f < 2*SLICES; f++) begin
            drive_cycle('0, '0, 1'b0);
        end

        // first cycle is the read_out strobe, two extra reads cover the drained queue
        for (int i = 0; i < ELEMS + 2; i++) begin
            drive_cycle('0, '0, (i == 0));
            label = $sformatf("%s[%0d]", test_name[idx], i);
            if (i < ELEMS) begin
                check_value(label, expected_byte(i), result);
            end else begin
                check_value(label, 0, result);
            end
        end
    endtask

    initial begin
        reset       = 1'b1;
        weights     = '0;
        activations = '0;
        read_out    = 1'b0;
        phase       = 0;
        lfsr_state  = LFSR_SEED;
        load_table();

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        // slice counter restarts at 0 out of reset
        phase = 0;

        // queue is cleared by reset, so result is 0 right away
        check_value("after_reset", 0, result);

        for (int idx = 0; idx < NUM_TESTS; idx++) begin
            run_test(idx);
        end

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
rtl/ternary_matmul_pkg.sv
rtl/trit_unpacker.sv
rtl/window_loader.sv
rtl/mac_array.sv
rtl/result_queue.sv
rtl/ternary_matmul.sv
sim/tb_ternary_matmul.sv

// File: run_sim.sh
#!/bin/sh
# build the ternary matmul testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_ternary_matmul \
    -f all.f -o tb_ternary_matmul_sim \
    || { echo "build failed"; exit 1; }

./obj_dir/tb_ternary_matmul_sim | tee /dev/stderr | grep -q "^Test OK$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
